// ==== common/mipsPkg.sv ====
package mipsPkg;

	// Primary opcode field, IR[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,	// Funct picks the operation
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0A,
		OP_LUI   = 6'h0F,
		OP_LW    = 6'h23,
		OP_SB    = 6'h28,
		OP_SH    = 6'h29,
		OP_SW    = 6'h2B
	} opcodeT;

	// R-type funct field, IR[5:0]
	typedef enum logic [5:0] {
		FN_JR  = 6'h08,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2A
	} functT;

	typedef enum logic [2:0] {ADD, SUB, AND, OR, LESS, PASS_A} aluOpT;

	// Multicycle sequencer states
	typedef enum logic [4:0] {
		FETCH, FETCH_WAIT1, FETCH_WAIT2, DECODE,
		RTYPE, ITYPE, SLT_WB, ALU_WB, LUI,
		MEM_ADDR, LOAD_WAIT1, LOAD_WAIT2, LOAD_WB, STORE,
		BRANCH, JUMP, JAL, JR, HALT
	} stateT;

	typedef enum logic [1:0] {WORD, HALF, BYTE} storeSizeT;	// Store width

	// Register writeback source
	typedef enum logic [1:0] {ALUOUT, MDR, UPPER_IMM, LINK} wbSrcT;

	// Next PC source
	typedef enum logic [1:0] {
		SEQUENTIAL,	// PC+4 straight from the ALU
		BRANCH_TARGET,	// Computed in DECODE, held in ALUOut
		JUMP_TARGET,
		REGISTER	// rs for JR
	} pcSrcT;

	// Owner of an outstanding memory read
	typedef enum logic [1:0] {REQ_NONE, REQ_FETCH, REQ_LS} memOwnerT;

endpackage

// ==== common/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath and address width
`define DATA_W 32

// Register file size
`define REG_COUNT 32
`define REG_IDX_W 5

// First fetch address
`define RESET_PC 32'h0000_0000

// Destination of JAL
`define LINK_REG 5'd31

// Cycles from read request to valid read data
`define MEM_LATENCY 2

`endif

// ==== control/controlFsm.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module controlFsm (
	input logic Clk,
	input logic Reset,
	input logic Break,
	input mipsPkg::opcodeT Opcode,
	input mipsPkg::functT Funct,
	input logic Zero,
	output logic FetchReq,
	output logic PcWrite,
	output mipsPkg::pcSrcT PcSel,
	output logic IrWrite,
	output logic LsReq,
	output logic LsWrite,
	output mipsPkg::storeSizeT StoreSize,
	output logic MdrLoad,
	output logic AbLoad,
	output mipsPkg::aluOpT AluOp,
	output logic AluSrcA,
	output logic [1:0] AluSrcB,
	output logic AluOutLoad,
	output logic RegWrite,
	output logic [1:0] RegDst,
	output mipsPkg::wbSrcT WbSrc,
	output logic Halted
);
	import mipsPkg::*;

	stateT state, nextState;
	logic started;	// Low for the first cycle out of reset
	storeSizeT storeSize;	// Latched in DECODE
	logic branchOnEq;	// BEQ when set, BNE otherwise

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= FETCH;
			started <= 1'b0;
			storeSize <= WORD;
			branchOnEq <= 1'b0;
		end else begin
			started <= 1'b1;
			state <= Break ? HALT : nextState;	// Break wins from any state
			if (state == DECODE) begin
				storeSize <= (Opcode == OP_SB) ? BYTE : (Opcode == OP_SH) ? HALF : WORD;
				branchOnEq <= (Opcode == OP_BEQ);
			end
		end
	end

	always_comb begin
		nextState = FETCH;	// Single-cycle tails go back to fetch
		case (state)
			FETCH: nextState = started ? FETCH_WAIT1 : FETCH;
			FETCH_WAIT1: nextState = FETCH_WAIT2;
			FETCH_WAIT2: nextState = DECODE;
			DECODE: begin
				case (Opcode)
					OP_RTYPE: begin
						case (Funct)
							FN_JR: nextState = JR;
							FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: nextState = RTYPE;
							default: nextState = FETCH;	// Unknown funct skipped
						endcase
					end
					OP_ADDI, OP_SLTI: nextState = ITYPE;
					OP_LUI: nextState = LUI;
					OP_LW, OP_SW, OP_SB, OP_SH: nextState = MEM_ADDR;
					OP_BEQ, OP_BNE: nextState = BRANCH;
					OP_J: nextState = JUMP;
					OP_JAL: nextState = JAL;
					default: nextState = FETCH;	// Unknown opcode
				endcase
			end
			RTYPE: nextState = (Funct == FN_SLT) ? SLT_WB : ALU_WB;
			ITYPE: nextState = (Opcode == OP_SLTI) ? SLT_WB : ALU_WB;
			MEM_ADDR: nextState = (Opcode == OP_LW) ? LOAD_WAIT1 : STORE;
			LOAD_WAIT1: nextState = LOAD_WAIT2;
			LOAD_WAIT2: nextState = LOAD_WB;
			HALT: nextState = HALT;	// Parked until Reset
			default: nextState = FETCH;
		endcase
	end

	always_comb begin
		FetchReq = 1'b0;
		PcWrite = 1'b0;
		PcSel = SEQUENTIAL;
		IrWrite = 1'b0;
		LsReq = 1'b0;
		LsWrite = 1'b0;
		StoreSize = WORD;
		MdrLoad = 1'b0;
		AbLoad = 1'b0;
		AluOp = ADD;
		AluSrcA = 1'b0;	// PC
		AluSrcB = 2'd0;	// B
		AluOutLoad = 1'b0;
		RegWrite = 1'b0;
		RegDst = 2'd0;	// rt
		WbSrc = ALUOUT;
		Halted = 1'b0;
		case (state)
			FETCH: FetchReq = started;	// Read at PC
			FETCH_WAIT2: begin	// Instruction word arrives
				IrWrite = 1'b1;
				PcWrite = 1'b1;
				AluSrcB = 2'd1;	// PC + 4
			end
			DECODE: begin
				AbLoad = 1'b1;	// rs and rt into A/B
				AluSrcB = 2'd3;	// PC + (imm << 2)
				AluOutLoad = 1'b1;	// Branch target kept in ALUOut
			end
			RTYPE: begin
				AluSrcA = 1'b1;
				AluOutLoad = 1'b1;
				case (Funct)
					FN_SUB: AluOp = SUB;
					FN_AND: AluOp = AND;
					FN_OR: AluOp = OR;
					FN_SLT: AluOp = LESS;	// 0/1 straight into ALUOut
					default: AluOp = ADD;
				endcase
			end
			ITYPE: begin
				AluSrcA = 1'b1;
				AluSrcB = 2'd2;	// Sign-extended imm
				AluOp = (Opcode == OP_SLTI) ? LESS : ADD;
				AluOutLoad = 1'b1;
			end
			ALU_WB, SLT_WB: begin
				RegWrite = 1'b1;
				RegDst = (Opcode == OP_RTYPE) ? 2'd1 : 2'd0;	// rd for R-type
			end
			LUI: begin
				RegWrite = 1'b1;
				WbSrc = UPPER_IMM;
			end
			MEM_ADDR: begin
				AluSrcA = 1'b1;	// A + imm is the address
				AluSrcB = 2'd2;
				LsReq = (Opcode == OP_LW);	// Loads issue right away
			end
			LOAD_WAIT2: MdrLoad = 1'b1;	// Data valid this cycle
			LOAD_WB: begin
				RegWrite = 1'b1;
				WbSrc = MDR;
			end
			STORE: begin
				AluSrcA = 1'b1;	// Address held on the ALU
				AluSrcB = 2'd2;
				LsReq = 1'b1;
				LsWrite = 1'b1;
				StoreSize = storeSize;
			end
			BRANCH: begin
				AluSrcA = 1'b1;
				AluOp = SUB;	// Zero means rs == rt
				PcSel = BRANCH_TARGET;
				PcWrite = (Zero == branchOnEq);
			end
			JUMP: begin
				PcWrite = 1'b1;
				PcSel = JUMP_TARGET;
			end
			JAL: begin
				PcWrite = 1'b1;
				PcSel = JUMP_TARGET;
				RegWrite = 1'b1;	// Old PC is already PC+4
				RegDst = 2'd2;
				WbSrc = LINK;
			end
			JR: begin
				AluSrcA = 1'b1;
				AluOp = PASS_A;
				PcWrite = 1'b1;
				PcSel = REGISTER;
			end
			HALT: Halted = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== src.f ====
+incdir+common
common/mipsPkg.sv
control/controlFsm.sv
src/fetchUnit.sv
src/loadStoreUnit.sv
src/memArbiter.sv
src/execUnit.sv
src/mipsCore.sv
test/memModel.sv
test/tbMipsCore.sv

// ==== src/execUnit.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module execUnit (
	input logic Clk,
	input logic Reset,
	input logic [`DATA_W-1:0] Instr,
	input logic [`DATA_W-1:0] Pc,
	input logic [`DATA_W-1:0] Mdr,
	input logic AbLoad,
	input mipsPkg::aluOpT AluOp,
	input logic AluSrcA,
	input logic [1:0] AluSrcB,
	input logic AluOutLoad,
	input logic RegWrite,
	input logic [1:0] RegDst,
	input mipsPkg::wbSrcT WbSrc,
	output logic [`DATA_W-1:0] RegA,
	output logic [`DATA_W-1:0] RegB,
	output logic [`DATA_W-1:0] AluResult,
	output logic [`DATA_W-1:0] AluOut,
	output logic Zero
);
	import mipsPkg::*;

	logic [`DATA_W-1:0] regFile [`REG_COUNT];
	logic [`REG_IDX_W-1:0] rs, rt, rd, wrIdx;
	logic [`DATA_W-1:0] rsData, rtData;
	logic [`DATA_W-1:0] signImm, upperImm;
	logic [`DATA_W-1:0] aluA, aluB, wrData;

	assign rs = Instr[25:21];
	assign rt = Instr[20:16];
	assign rd = Instr[15:11];
	assign signImm = {{(`DATA_W-16){Instr[15]}}, Instr[15:0]};
	assign upperImm = {Instr[15:0], {(`DATA_W-16){1'b0}}};	// LUI value

	// r0 always reads zero
	assign rsData = (rs == '0) ? '0 : regFile[rs];
	assign rtData = (rt == '0) ? '0 : regFile[rt];

	always_comb begin
		case (RegDst)
			2'd1: wrIdx = rd;
			2'd2: wrIdx = `LINK_REG;	// JAL
			default: wrIdx = rt;
		endcase
		case (WbSrc)
			MDR: wrData = Mdr;
			UPPER_IMM: wrData = upperImm;
			LINK: wrData = Pc;	// PC+4 since fetch
			default: wrData = AluOut;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (RegWrite)
			regFile[wrIdx] <= wrData;
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			RegA <= '0;
			RegB <= '0;
			AluOut <= '0;
		end else begin
			if (AbLoad) begin
				RegA <= rsData;
				RegB <= rtData;
			end
			if (AluOutLoad)
				AluOut <= AluResult;
		end
	end

	assign aluA = AluSrcA ? RegA : Pc;

	always_comb begin
		case (AluSrcB)
			2'd1: aluB = `DATA_W'(4);
			2'd2: aluB = signImm;
			2'd3: aluB = {signImm[`DATA_W-3:0], 2'b00};	// Branch offset in words
			default: aluB = RegB;
		endcase
		case (AluOp)
			SUB: AluResult = aluA - aluB;
			AND: AluResult = aluA & aluB;
			OR: AluResult = aluA | aluB;
			LESS: AluResult = {{(`DATA_W-1){1'b0}}, $signed(aluA) < $signed(aluB)};	// Signed SLT
			PASS_A: AluResult = aluA;
			default: AluResult = aluA + aluB;
		endcase
	end

	assign Zero = (AluResult == '0);

endmodule

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module fetchUnit (
	input logic Clk,
	input logic Reset,
	input logic PcWrite,
	input mipsPkg::pcSrcT PcSel,
	input logic IrWrite,
	input logic FetchRdValid,
	input logic [`DATA_W-1:0] RdData,
	input logic [`DATA_W-1:0] AluResult,
	input logic [`DATA_W-1:0] AluOut,
	input logic [`DATA_W-1:0] RegA,
	output logic [`DATA_W-1:0] Pc,
	output logic [`DATA_W-1:0] Instr,
	output mipsPkg::opcodeT Opcode,
	output mipsPkg::functT Funct
);
	import mipsPkg::*;

	logic [`DATA_W-1:0] nextPc;
	logic [`DATA_W-1:0] jumpTarget;

	// Region bits of PC+4 with the word index
	assign jumpTarget = {Pc[`DATA_W-1 -: 4], Instr[25:0], 2'b00};

	always_comb begin
		case (PcSel)
			SEQUENTIAL: nextPc = AluResult;	// ALU adds 4
			BRANCH_TARGET: nextPc = AluOut;
			JUMP_TARGET: nextPc = jumpTarget;
			REGISTER: nextPc = RegA;	// JR
			default: nextPc = AluResult;
		endcase
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset)
			Pc <= `RESET_PC;
		else if (PcWrite)
			Pc <= nextPc;
	end

	// IR only takes a word returned for fetch
	always_ff @(posedge Clk) begin
		if (IrWrite && FetchRdValid)
			Instr <= RdData;
	end

	assign Opcode = opcodeT'(Instr[31:26]);
	assign Funct = functT'(Instr[5:0]);

endmodule

// ==== src/loadStoreUnit.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module loadStoreUnit (
	input logic Clk,
	input logic Reset,
	input logic [`DATA_W-1:0] AddrIn,
	input logic [`DATA_W-1:0] StoreData,
	input mipsPkg::storeSizeT StoreSize,
	input logic MdrLoad,
	input logic LsRdValid,
	input logic [`DATA_W-1:0] RdData,
	output logic [`DATA_W-1:0] LsAddr,
	output logic [`DATA_W-1:0] LsWdata,
	output logic [3:0] LsByteEn,
	output logic [`DATA_W-1:0] Mdr
);
	import mipsPkg::*;

	logic [1:0] laneSel;

	assign laneSel = AddrIn[1:0];
	assign LsAddr = {AddrIn[`DATA_W-1:2], 2'b00};	// Word aligned, lanes via byte enables

	// Little-endian lanes, data copied into every lane it could use
	always_comb begin
		case (StoreSize)
			BYTE: begin
				LsByteEn = 4'b0001 << laneSel;
				LsWdata = {4{StoreData[7:0]}};
			end
			HALF: begin
				LsByteEn = laneSel[1] ? 4'b1100 : 4'b0011;	// Bit 0 ignored
				LsWdata = {2{StoreData[15:0]}};
			end
			default: begin
				LsByteEn = 4'b1111;
				LsWdata = StoreData;
			end
		endcase
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset)
			Mdr <= '0;
		else if (MdrLoad && LsRdValid)	// Only a load's own return
			Mdr <= RdData;
	end

endmodule

// ==== src/memArbiter.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module memArbiter (
	input logic Clk,
	input logic Reset,
	input logic FetchReq,
	input logic [`DATA_W-1:0] FetchAddr,
	input logic LsReq,
	input logic LsWrite,
	input logic [`DATA_W-1:0] LsAddr,
	input logic [`DATA_W-1:0] LsWdata,
	input logic [3:0] LsByteEn,
	output logic [`DATA_W-1:0] MemAddr,
	output logic MemRead,
	output logic MemWrite,
	output logic [`DATA_W-1:0] MemWdata,
	output logic [3:0] MemByteEn,
	output logic FetchRdValid,
	output logic LsRdValid
);
	import mipsPkg::*;

	memOwnerT issueOwner;
	memOwnerT ownerPipe [`MEM_LATENCY];	// One slot per cycle of read latency

	// Load/store has fixed priority
	assign MemAddr = LsReq ? LsAddr : FetchAddr;
	assign MemWrite = LsReq && LsWrite;
	assign MemRead = LsReq ? !LsWrite : FetchReq;
	assign MemWdata = LsWdata;
	assign MemByteEn = MemWrite ? LsByteEn : 4'b1111;	// Reads return the full word

	assign issueOwner = !MemRead ? REQ_NONE : LsReq ? REQ_LS : REQ_FETCH;

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < `MEM_LATENCY; i++)
				ownerPipe[i] <= REQ_NONE;
		end else begin
			ownerPipe[0] <= issueOwner;
			for (int i = 1; i < `MEM_LATENCY; i++)
				ownerPipe[i] <= ownerPipe[i-1];
		end
	end

	// Last slot lines up with the data coming back
	assign FetchRdValid = (ownerPipe[`MEM_LATENCY-1] == REQ_FETCH);
	assign LsRdValid = (ownerPipe[`MEM_LATENCY-1] == REQ_LS);

endmodule

// ==== src/mipsCore.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module mipsCore (
	input logic Clk,
	input logic Reset,
	input logic Break,
	input logic [`DATA_W-1:0] MemRdata,
	output logic [`DATA_W-1:0] MemAddr,
	output logic [`DATA_W-1:0] MemWdata,
	output logic [3:0] MemByteEn,
	output logic MemRead,
	output logic MemWrite,
	output logic Halted
);
	import mipsPkg::*;

	logic fetchReq, pcWrite, irWrite, lsReq, lsWrite, mdrLoad, abLoad;
	logic aluSrcA, aluOutLoad, regWrite, zero, fetchRdValid, lsRdValid;
	logic [1:0] aluSrcB, regDst;
	pcSrcT pcSel;
	storeSizeT storeSize;
	aluOpT aluOp;
	wbSrcT wbSrc;
	opcodeT opcode;
	functT funct;
	logic [`DATA_W-1:0] pc, instr, aluResult, aluOut, regA, regB, mdr;
	logic [`DATA_W-1:0] lsAddr, lsWdata;
	logic [3:0] lsByteEn;

	controlFsm ctrl (.Clk, .Reset, .Break, .Opcode(opcode), .Funct(funct), .Zero(zero),
		.FetchReq(fetchReq), .PcWrite(pcWrite), .PcSel(pcSel), .IrWrite(irWrite),
		.LsReq(lsReq), .LsWrite(lsWrite), .StoreSize(storeSize), .MdrLoad(mdrLoad),
		.AbLoad(abLoad), .AluOp(aluOp), .AluSrcA(aluSrcA), .AluSrcB(aluSrcB),
		.AluOutLoad(aluOutLoad), .RegWrite(regWrite), .RegDst(regDst), .WbSrc(wbSrc),
		.Halted);

	fetchUnit fetch (.Clk, .Reset, .PcWrite(pcWrite), .PcSel(pcSel), .IrWrite(irWrite),
		.FetchRdValid(fetchRdValid), .RdData(MemRdata), .AluResult(aluResult),
		.AluOut(aluOut), .RegA(regA), .Pc(pc), .Instr(instr), .Opcode(opcode),
		.Funct(funct));

	// Store data is rt from B, address straight off the ALU
	loadStoreUnit ls (.Clk, .Reset, .AddrIn(aluResult), .StoreData(regB),
		.StoreSize(storeSize), .MdrLoad(mdrLoad), .LsRdValid(lsRdValid), .RdData(MemRdata),
		.LsAddr(lsAddr), .LsWdata(lsWdata), .LsByteEn(lsByteEn), .Mdr(mdr));

	execUnit exec (.Clk, .Reset, .Instr(instr), .Pc(pc), .Mdr(mdr), .AbLoad(abLoad),
		.AluOp(aluOp), .AluSrcA(aluSrcA), .AluSrcB(aluSrcB), .AluOutLoad(aluOutLoad),
		.RegWrite(regWrite), .RegDst(regDst), .WbSrc(wbSrc), .RegA(regA), .RegB(regB),
		.AluResult(aluResult), .AluOut(aluOut), .Zero(zero));

	memArbiter arb (.Clk, .Reset, .FetchReq(fetchReq), .FetchAddr(pc), .LsReq(lsReq),
		.LsWrite(lsWrite), .LsAddr(lsAddr), .LsWdata(lsWdata), .LsByteEn(lsByteEn),
		.MemAddr, .MemRead, .MemWrite, .MemWdata, .MemByteEn,
		.FetchRdValid(fetchRdValid), .LsRdValid(lsRdValid));

endmodule

// ==== test/memModel.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module memModel #(
	parameter int DEPTH = 256	// Words
) (
	input logic Clk,
	input logic [`DATA_W-1:0] MemAddr,
	input logic MemRead,
	input logic MemWrite,
	input logic [`DATA_W-1:0] MemWdata,
	input logic [3:0] MemByteEn,
	output logic [`DATA_W-1:0] MemRdata
);

	localparam int IDX_W = $clog2(DEPTH);

	logic [`DATA_W-1:0] mem [DEPTH];	// Preloaded by the testbench
	logic [`DATA_W-1:0] rdPipe [`MEM_LATENCY];	// One stage per latency cycle
	logic [IDX_W-1:0] wordIdx;

	assign wordIdx = MemAddr[IDX_W+1:2];	// Byte lanes come from MemByteEn

	initial begin
		for (int i = 0; i < `MEM_LATENCY; i++)
			rdPipe[i] = '0;
	end

	always @(posedge Clk) begin
		if (MemWrite) begin
			for (int b = 0; b < 4; b++)
				if (MemByteEn[b])
					mem[wordIdx][8*b +: 8] <= MemWdata[8*b +: 8];	// Lane b only
		end
		rdPipe[0] <= MemRead ? mem[wordIdx] : 'x;	// Idle cycles return X
		for (int i = 1; i < `MEM_LATENCY; i++)
			rdPipe[i] <= rdPipe[i-1];
	end

	// Read issued in cycle n shows up here in cycle n + latency
	assign MemRdata = rdPipe[`MEM_LATENCY-1];

endmodule

// ==== test/tbMipsCore.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module tbMipsCore;

	localparam logic [5:0]
		OP_R = 6'h00,
		OP_J = 6'h02,
		OP_JAL = 6'h03,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_ADDI = 6'h08,
		OP_SLTI = 6'h0A,
		OP_LUI = 6'h0F,
		OP_LW = 6'h23,
		OP_SB = 6'h28,
		OP_SH = 6'h29,
		OP_SW = 6'h2B;
	localparam logic [5:0]
		FN_JR = 6'h08,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_SLT = 6'h2A;
	localparam int MEM_WORDS = 256;
	localparam int WAIT_LIMIT = 300;	// Cycles per wait

	logic Clk, Reset, Break;
	logic [`DATA_W-1:0] MemRdata, MemAddr, MemWdata;
	logic [3:0] MemByteEn;
	logic MemRead, MemWrite, Halted;
	int errors = 0;
	int checks = 0;
	integer seed;
	logic [31:0] progWords [$];	// Program being assembled

	mipsCore UUT (.Clk, .Reset, .Break, .MemRdata, .MemAddr, .MemWdata, .MemByteEn,
		.MemRead, .MemWrite, .Halted);

	memModel #(.DEPTH(MEM_WORDS)) memory (.Clk, .MemAddr, .MemRead, .MemWrite, .MemWdata,
		.MemByteEn, .MemRdata);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;	// 40 ns period
	end

	function automatic logic [31:0] rTypeWord(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {OP_R, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] immWord(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jumpWord(input logic [5:0] op, input int idx);
		return {op, 26'(idx)};	// Word index, region bits are zero here
	endfunction

	// Offset counts words from the slot after the branch
	function automatic logic [31:0] branchWord(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input int fromIdx, input int toIdx);
		return immWord(op, rs, rt, 16'(toIdx - fromIdx - 1));
	endfunction

	function automatic logic [31:0] laneMask(input logic [3:0] be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	function automatic logic [31:0] signedLess(input logic [31:0] a, input logic [31:0] b);
		return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	endfunction

	task automatic emit(input logic [31:0] word);
		progWords.push_back(word);
	endtask

	// LUI then ADDI, upper half bumped to undo the sign extension
	task automatic emitConst(input logic [4:0] rd, input logic [31:0] val);
		logic [15:0] hi;
		hi = val[31:16] + {15'd0, val[15]};
		emit(immWord(OP_LUI, 5'd0, rd, hi));
		emit(immWord(OP_ADDI, rd, rd, val[15:0]));
	endtask

	// Core held in reset while memory is rewritten
	task automatic loadProgram();
		@(posedge Clk);
		Reset <= 1'b1;
		repeat (3) @(posedge Clk);
		for (int i = 0; i < MEM_WORDS; i++)
			memory.mem[i] = 32'h5A5A_0000 ^ (i * 4);	// Unknown opcode everywhere
		foreach (progWords[i])
			memory.mem[i] = progWords[i];
		progWords.delete();
	endtask

	task automatic releaseReset();
		@(posedge Clk);
		Reset <= 1'b0;	// Fourth cycle of reset ends here
	endtask

	task automatic waitForWrite(output logic [31:0] addr, output logic [31:0] data,
		output logic [3:0] be, output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		addr = 'x;
		data = 'x;
		be = 'x;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge Clk);	// Port settled mid-cycle
			cycles++;
			if (MemWrite === 1'b1) begin
				seen = 1'b1;
				addr = MemAddr;
				data = MemWdata;
				be = MemByteEn;
			end
		end
	endtask

	// Next write against word address, lanes and the data in those lanes
	task automatic checkWrite(input string testName, input logic [31:0] expAddr,
		input logic [31:0] expData, input logic [3:0] expBe);
		logic [31:0] gotAddr, gotData, mask;
		logic [3:0] gotBe;
		bit seen;
		waitForWrite(gotAddr, gotData, gotBe, seen);
		mask = laneMask(expBe);
		checks++;
		assert (seen) else begin
			errors++;
			$display("%s: no memory write within %0d cycles", testName, WAIT_LIMIT);
		end
		if (seen) begin
			assert (gotAddr[31:2] == expAddr[31:2]) else begin
				errors++;
				$display("[ERROR] %s: write address expected %h, actual %h", testName,
					{expAddr[31:2], 2'b00}, gotAddr);
			end
			assert (gotBe == expBe) else begin
				errors++;
				$display("[ERROR] %s: byte enables expected %b, actual %b", testName,
					expBe, gotBe);
			end
			assert ((gotData & mask) == (expData & mask)) else begin
				errors++;
				$display("[ERROR] %s: write data expected %h, actual %h", testName,
					expData & mask, gotData & mask);
			end
		end
	endtask

	task automatic expectNoWrite(input string testName, input int cycles);
		int seenWrites;
		seenWrites = 0;
		repeat (cycles) begin
			@(negedge Clk);
			if (MemWrite !== 1'b0)
				seenWrites++;
		end
		checks++;
		assert (seenWrites == 0) else begin
			errors++;
			$display("[ERROR] %s: stray write cycles expected %0d, actual %0d", testName, 0,
				seenWrites);
		end
	endtask

	task automatic arithTest();
		logic [31:0] a, b, immExt;
		logic [15:0] imm;
		for (int round = 0; round < 3; round++) begin
			a = $random(seed);
			b = $random(seed);
			imm = $random(seed);
			immExt = {{16{imm[15]}}, imm};
			emitConst(5'd1, a);
			emitConst(5'd2, b);
			emit(rTypeWord(FN_ADD, 5'd1, 5'd2, 5'd3));
			emit(immWord(OP_SW, 5'd0, 5'd3, 16'h200));
			emit(rTypeWord(FN_SUB, 5'd1, 5'd2, 5'd4));
			emit(immWord(OP_SW, 5'd0, 5'd4, 16'h204));
			emit(rTypeWord(FN_AND, 5'd1, 5'd2, 5'd5));
			emit(immWord(OP_SW, 5'd0, 5'd5, 16'h208));
			emit(rTypeWord(FN_OR, 5'd1, 5'd2, 5'd6));
			emit(immWord(OP_SW, 5'd0, 5'd6, 16'h20C));
			emit(rTypeWord(FN_SLT, 5'd1, 5'd2, 5'd7));	// a < b
			emit(immWord(OP_SW, 5'd0, 5'd7, 16'h210));
			emit(rTypeWord(FN_SLT, 5'd2, 5'd1, 5'd8));	// b < a
			emit(immWord(OP_SW, 5'd0, 5'd8, 16'h214));
			emit(immWord(OP_SLTI, 5'd1, 5'd9, imm));
			emit(immWord(OP_SW, 5'd0, 5'd9, 16'h218));
			emit(jumpWord(OP_J, progWords.size()));	// Park
			loadProgram();
			releaseReset();
			checkWrite("arith", 32'h200, a + b, 4'hF);
			checkWrite("arith", 32'h204, a - b, 4'hF);
			checkWrite("arith", 32'h208, a & b, 4'hF);
			checkWrite("arith", 32'h20C, a | b, 4'hF);
			checkWrite("arith", 32'h210, signedLess(a, b), 4'hF);
			checkWrite("arith", 32'h214, signedLess(b, a), 4'hF);
			checkWrite("arith", 32'h218, signedLess(a, immExt), 4'hF);
		end
	endtask

	task automatic loadTest();
		logic [31:0] first, second;
		first = $random(seed);
		second = $random(seed);
		emit(immWord(OP_LW, 5'd0, 5'd1, 16'h300));
		emit(immWord(OP_SW, 5'd0, 5'd1, 16'h204));
		emit(immWord(OP_ADDI, 5'd0, 5'd2, 16'h310));
		emit(immWord(OP_LW, 5'd2, 5'd3, 16'hFFFC));	// Negative offset, 0x30C
		emit(immWord(OP_SW, 5'd0, 5'd3, 16'h208));
		emit(jumpWord(OP_J, progWords.size()));
		loadProgram();
		memory.mem[32'h300 >> 2] = first;
		memory.mem[32'h30C >> 2] = second;
		releaseReset();
		checkWrite("load", 32'h204, first, 4'hF);
		checkWrite("load", 32'h208, second, 4'hF);
	endtask

	task automatic narrowStoreTest();
		logic [31:0] val;
		val = $random(seed);
		emitConst(5'd1, val);
		for (int k = 0; k < 4; k++)
			emit(immWord(OP_SB, 5'd0, 5'd1, 16'(16'h200 + k)));
		emit(immWord(OP_SH, 5'd0, 5'd1, 16'h210));
		emit(immWord(OP_SH, 5'd0, 5'd1, 16'h212));
		emit(jumpWord(OP_J, progWords.size()));
		loadProgram();
		releaseReset();
		for (int k = 0; k < 4; k++)
			checkWrite("narrowStore", 32'h200 + k, {24'd0, val[7:0]} << (8 * k),
				4'b0001 << k);
		checkWrite("narrowStore", 32'h210, {16'd0, val[15:0]}, 4'b0011);
		checkWrite("narrowStore", 32'h212, {val[15:0], 16'd0}, 4'b1100);
	endtask

	task automatic controlFlowTest();
		emit(immWord(OP_ADDI, 5'd0, 5'd1, 16'd5));	// 0
		emit(immWord(OP_ADDI, 5'd0, 5'd2, 16'd5));
		emit(immWord(OP_ADDI, 5'd0, 5'd3, 16'd7));
		emit(immWord(OP_ADDI, 5'd0, 5'd10, 16'h0A1));	// Markers
		emit(immWord(OP_ADDI, 5'd0, 5'd11, 16'h0B1));	// Wrong path
		emit(immWord(OP_ADDI, 5'd0, 5'd12, 16'h0C1));
		emit(immWord(OP_ADDI, 5'd0, 5'd13, 16'h0D1));
		emit(immWord(OP_ADDI, 5'd0, 5'd14, 16'h0E1));
		emit(immWord(OP_ADDI, 5'd0, 5'd15, 16'h0F1));
		emit(branchWord(OP_BEQ, 5'd1, 5'd2, 9, 11));	// 9, taken
		emit(immWord(OP_SW, 5'd0, 5'd11, 16'h280));
		emit(immWord(OP_SW, 5'd0, 5'd10, 16'h200));
		emit(branchWord(OP_BEQ, 5'd1, 5'd3, 12, 14));	// 12, falls through
		emit(immWord(OP_SW, 5'd0, 5'd12, 16'h204));
		emit(branchWord(OP_BNE, 5'd1, 5'd3, 14, 16));	// 14, taken
		emit(immWord(OP_SW, 5'd0, 5'd11, 16'h284));
		emit(immWord(OP_SW, 5'd0, 5'd13, 16'h208));
		emit(branchWord(OP_BNE, 5'd1, 5'd2, 17, 19));	// 17, falls through
		emit(immWord(OP_SW, 5'd0, 5'd14, 16'h20C));
		emit(jumpWord(OP_J, 21));	// 19
		emit(immWord(OP_SW, 5'd0, 5'd11, 16'h288));
		emit(immWord(OP_SW, 5'd0, 5'd15, 16'h210));
		emit(jumpWord(OP_JAL, 26));	// 22, returns to 23
		emit(immWord(OP_SW, 5'd0, 5'd31, 16'h214));
		emit(jumpWord(OP_J, 24));
		emit(immWord(OP_SW, 5'd0, 5'd11, 16'h28C));
		emit(immWord(OP_ADDI, 5'd0, 5'd16, 16'h101));	// 26, subroutine
		emit(immWord(OP_SW, 5'd0, 5'd16, 16'h218));
		emit(rTypeWord(FN_JR, 5'd31, 5'd0, 5'd0));
		loadProgram();
		releaseReset();
		checkWrite("controlFlow", 32'h200, 32'h0A1, 4'hF);
		checkWrite("controlFlow", 32'h204, 32'h0C1, 4'hF);
		checkWrite("controlFlow", 32'h208, 32'h0D1, 4'hF);
		checkWrite("controlFlow", 32'h20C, 32'h0E1, 4'hF);
		checkWrite("controlFlow", 32'h210, 32'h0F1, 4'hF);
		checkWrite("controlFlow", 32'h218, 32'h101, 4'hF);
		checkWrite("controlFlow", 32'h214, 22 * 4 + 4, 4'hF);	// JAL address + 4
		expectNoWrite("controlFlow", 60);
	endtask

	task automatic resetBreakTest();
		int cycles;
		int busyCycles;
		bit seen;
		emit(immWord(OP_ADDI, 5'd0, 5'd1, 16'd1));
		emit(immWord(OP_SW, 5'd0, 5'd1, 16'h200));
		emit(jumpWord(OP_J, 1));	// Store loop
		loadProgram();
		releaseReset();
		@(negedge Clk);	// First cycle out of reset
		checks++;
		assert (!MemRead && !MemWrite && !Halted && !UUT.regWrite && !UUT.pcWrite) else begin
			errors++;
			$display("resetBreak: control outputs active in the first cycle after reset");
		end
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge Clk);
			cycles++;
			seen = MemRead || MemWrite;
		end
		checks++;
		assert (seen && MemRead && !MemWrite) else begin
			errors++;
			$display("resetBreak: first memory request after reset was not a read");
		end
		assert (MemAddr == `RESET_PC) else begin
			errors++;
			$display("[ERROR] resetBreak: first fetch address expected %h, actual %h",
				`RESET_PC, MemAddr);
		end
		checkWrite("resetBreak", 32'h200, 32'd1, 4'hF);	// Core is running
		@(posedge Clk);
		Break <= 1'b1;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge Clk);
			cycles++;
			seen = (Halted === 1'b1);
		end
		checks++;
		assert (seen) else begin
			errors++;
			$display("resetBreak: Halted never went high after Break");
		end
		@(posedge Clk);
		Break <= 1'b0;	// HALT holds without Break
		busyCycles = 0;
		repeat (50) begin
			@(negedge Clk);
			if (MemRead !== 1'b0 || MemWrite !== 1'b0 || Halted !== 1'b1)
				busyCycles++;
		end
		checks++;
		assert (busyCycles == 0) else begin
			errors++;
			$display("[ERROR] resetBreak: active cycles while halted expected %0d, actual %0d",
				0, busyCycles);
		end
	endtask

	initial begin
		Reset = 1'b1;
		Break = 1'b0;
		seed = 32'h36f;
		arithTest();
		loadTest();
		narrowStoreTest();
		controlFlowTest();
		resetBreakTest();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
